/* Makefile */
# Verilator flow for the mips16 core and its testbench

TOP = mips16Tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

# the run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+include
design/mips16_pkg.sv
design/registerFile.sv
design/aluUnit.sv
design/datapath.sv
design/controlFsm.sv
design/mips16Core.sv
tests/mips16_properties.sv
tests/mips16Checker.sv
tests/mips16Tb.sv

/* design/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module aluUnit (
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	input  mips16_pkg::aluOp_t req,
	input  logic [3:0]        funct,
	input  logic              isRtype,
	output logic [`DATA_W-1:0] y
);
	import mips16_pkg::*;

	aluOp_t op;

	// R-type execute takes its op from funct
	assign op = isRtype ? functOp(funct) : req;

	always_comb
	begin
		case (op)
			ADD:     y = a + b;
			AND:     y = a & b;
			NOT:     y = ~a;
			SUB:     y = a - b;
			SLT:     y = {{(`DATA_W-1){1'b0}}, (a < b)};   // unsigned
			PASS:    y = b;
			default: y = a + b;
		endcase
	end

endmodule

`default_nettype wire

/* design/controlFsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module controlFsm (
	input  logic              clock,
	input  logic              rst,
	input  logic [2:0]        opcode,
	input  logic [3:0]        funct,
	output logic              pcWrite,
	output logic              branchEn,
	output logic              irWrite,
	output logic              regWrite,
	output logic              memRead,
	output logic              memWrite,
	output logic              aluASel,      // 1 selects PC
	output logic              pcSel,        // 1 selects jump target
	output logic [1:0]        aluBSel,
	output logic [1:0]        wbSel,
	output logic [1:0]        dstSel,
	output mips16_pkg::aluOp_t aluReq
);
	import mips16_pkg::*;

	cpuState_t state;
	cpuState_t nextState;

	always_ff @(posedge clock)
	begin
		if (rst)
			state <= FETCH;
		else
			state <= nextState;
	end

	// ------------------------------
	// next state
	// ------------------------------
	always_comb
	begin
		nextState = FETCH;
		case (state)
			FETCH:
				nextState = DECODE;
			DECODE:
			begin
				case (opcode)
					`OP_RTYPE:         nextState = EXEC_R;
					`OP_SLTI, `OP_ADDI: nextState = EXEC_I;
					`OP_LB, `OP_SW:     nextState = ADDR;
					`OP_BEQ:           nextState = BRANCH;
					`OP_JAL:           nextState = JUMP;
					default:           nextState = FETCH;  // opcode 1 is skipped
				endcase
			end
			EXEC_R, EXEC_I:
				nextState = WB_ALU;
			ADDR:
				nextState = (opcode == `OP_LB) ? MEM_RD : MEM_WR;
			MEM_RD:
				nextState = WB_LOAD;
			default:
				nextState = FETCH;                     // all final phases
		endcase
	end

	// ------------------------------
	// control decode
	// ------------------------------
	always_comb
	begin
		pcWrite  = 1'b0;
		branchEn = 1'b0;
		irWrite  = 1'b0;
		regWrite = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		pcSel    = 1'b0;
		aluASel  = 1'b1;                // idle ALU computes PC + 2
		aluBSel  = `BSEL_TWO;
		aluReq   = ADD;
		wbSel    = `WBSEL_ALU;
		dstSel   = `DST_RT;
		case (state)
			FETCH:
			begin
				memRead = !rst;         // bus stays quiet in reset
				irWrite = 1'b1;
				pcWrite = 1'b1;         // PC + 2 straight from the ALU
			end
			DECODE:
				aluBSel = `BSEL_BROFF;  // branch target into ALU-out
			EXEC_R:
			begin
				aluASel = 1'b0;
				aluBSel = `BSEL_REG;
				aluReq  = functOp(funct);
			end
			EXEC_I:
			begin
				aluASel = 1'b0;
				aluBSel = `BSEL_IMM;
				aluReq  = (opcode == `OP_SLTI) ? SLT : ADD;
			end
			WB_ALU:
			begin
				regWrite = 1'b1;
				dstSel   = (opcode == `OP_RTYPE) ? `DST_RD : `DST_RT;
			end
			ADDR:
			begin
				aluASel = 1'b0;         // A + sign-extended imm7
				aluBSel = `BSEL_IMM;
			end
			MEM_RD:
				memRead = 1'b1;
			WB_LOAD:
			begin
				regWrite = 1'b1;
				wbSel    = `WBSEL_MDR;
			end
			MEM_WR:
				memWrite = 1'b1;
			BRANCH:
				branchEn = 1'b1;        // datapath decides on A == B
			JUMP:
			begin
				regWrite = 1'b1;
				wbSel    = `WBSEL_PC;   // PC already holds the return address
				dstSel   = `DST_LINK;
				pcWrite  = 1'b1;
				pcSel    = 1'b1;
			end
			default:
				aluReq = ADD;
		endcase
	end

endmodule

`default_nettype wire

/* design/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module datapath (
	input  logic              clock,
	input  logic              rst,
	input  logic              pcWrite,
	input  logic              branchEn,
	input  logic              irWrite,
	input  logic              regWrite,
	input  logic              memRead,
	input  logic              aluASel,
	input  logic              pcSel,
	input  logic [1:0]        aluBSel,
	input  logic [1:0]        wbSel,
	input  logic [1:0]        dstSel,
	input  mips16_pkg::aluOp_t aluReq,
	output logic [2:0]        opcode,
	output logic [3:0]        funct,
	output logic [`DATA_W-1:0] memAddr,
	output logic [`DATA_W-1:0] memWrData,
	input  logic [`DATA_W-1:0] memRdData
);
	import mips16_pkg::*;

	instrWord_t         ir;
	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] mdr;
	logic [`DATA_W-1:0] aReg;
	logic [`DATA_W-1:0] bReg;
	logic [`DATA_W-1:0] aluOutReg;
	logic [`DATA_W-1:0] rfA;
	logic [`DATA_W-1:0] rfB;
	logic [`DATA_W-1:0] aluA;
	logic [`DATA_W-1:0] aluB;
	logic [`DATA_W-1:0] aluY;
	logic [`DATA_W-1:0] wrData;
	logic [`DATA_W-1:0] pcNext;
	logic [`DATA_W-1:0] immSext;
	logic [`DATA_W-1:0] immZext;
	logic [`DATA_W-1:0] jumpTarget;
	logic [`REG_AW-1:0] wrAddr;
	logic               takeBranch;
	logic               rExec;

	assign opcode = ir.rFmt.op;
	assign funct  = ir.rFmt.funct;

	assign immSext    = {{(`DATA_W-7){ir.iFmt.imm7[6]}}, ir.iFmt.imm7};
	assign immZext    = {{(`DATA_W-7){1'b0}}, ir.iFmt.imm7};
	assign jumpTarget = {pc[15:14], ir.iFmt.imm7, ir.iFmt.rt, ir.iFmt.rs, 1'b0};

	assign memAddr   = irWrite ? pc : aluOutReg;   // fetch or data access
	assign memWrData = bReg;

	// ------------------------------
	// PC and branch
	// ------------------------------
	assign takeBranch = branchEn && (aReg == bReg);
	assign pcNext     = branchEn ? aluOutReg : (pcSel ? jumpTarget : aluY);

	always_ff @(posedge clock)
	begin
		if (rst)
			pc <= '0;
		else if (pcWrite || takeBranch)
			pc <= pcNext;
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		if (irWrite)
			ir <= memRdData;
		if (memRead)
			mdr <= {{(`DATA_W-8){memRdData[7]}}, memRdData[7:0]};   // lb sign extend
		aReg      <= rfA;
		bReg      <= rfB;
		aluOutReg <= aluY;
	end

	// ------------------------------
	// ALU operands
	// ------------------------------
	assign aluA = aluASel ? pc : aReg;

	always_comb
	begin
		case (aluBSel)
			`BSEL_REG:   aluB = bReg;
			`BSEL_TWO:   aluB = `DATA_W'd2;
			`BSEL_BROFF: aluB = {immSext[`DATA_W-2:0], 1'b0};
			default:     aluB = (opcode == `OP_SLTI) ? immZext : immSext;
		endcase
	end

	// only R-type execute pairs A with B
	assign rExec = !aluASel && (aluBSel == `BSEL_REG) && (opcode == `OP_RTYPE);

	aluUnit alu (
		.a       (aluA),
		.b       (aluB),
		.req     (aluReq),
		.funct   (funct),
		.isRtype (rExec),
		.y       (aluY)
	);

	// write-back data and destination
	always_comb
	begin
		case (wbSel)
			`WBSEL_MDR: wrData = mdr;
			`WBSEL_PC:  wrData = pc;
			default:    wrData = aluOutReg;
		endcase
		case (dstSel)
			`DST_RD:   wrAddr = ir.rFmt.rd;
			`DST_LINK: wrAddr = `LINK_REG;
			default:   wrAddr = ir.iFmt.rt;
		endcase
	end

	registerFile regs (
		.clock   (clock),
		.rst     (rst),
		.rdAddrA (ir.iFmt.rs),
		.rdAddrB (ir.iFmt.rt),
		.wrAddr  (wrAddr),
		.wrEn    (regWrite),
		.wrData  (wrData),
		.rdDataA (rfA),
		.rdDataB (rfB)
	);

endmodule

`default_nettype wire

/* design/mips16Core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module mips16Core (
	input  logic              clock,
	input  logic              rst,
	output logic [`DATA_W-1:0] memAddr,
	output logic              memRead,
	output logic              memWrite,
	output logic [`DATA_W-1:0] memWrData,
	input  logic [`DATA_W-1:0] memRdData
);
	import mips16_pkg::*;

	logic       pcWrite;
	logic       branchEn;
	logic       irWrite;
	logic       regWrite;
	logic       aluASel;
	logic       pcSel;
	logic [1:0] aluBSel;
	logic [1:0] wbSel;
	logic [1:0] dstSel;
	logic [2:0] opcode;
	logic [3:0] funct;
	aluOp_t     aluReq;

	// ------------------------------
	// control and datapath
	// ------------------------------
	controlFsm ctrl (
		.clock    (clock),
		.rst      (rst),
		.opcode   (opcode),
		.funct    (funct),
		.pcWrite  (pcWrite),
		.branchEn (branchEn),
		.irWrite  (irWrite),
		.regWrite (regWrite),
		.memRead  (memRead),
		.memWrite (memWrite),
		.aluASel  (aluASel),
		.pcSel    (pcSel),
		.aluBSel  (aluBSel),
		.wbSel    (wbSel),
		.dstSel   (dstSel),
		.aluReq   (aluReq)
	);

	datapath dp (
		.clock     (clock),
		.rst       (rst),
		.pcWrite   (pcWrite),
		.branchEn  (branchEn),
		.irWrite   (irWrite),
		.regWrite  (regWrite),
		.memRead   (memRead),
		.aluASel   (aluASel),
		.pcSel     (pcSel),
		.aluBSel   (aluBSel),
		.wbSel     (wbSel),
		.dstSel    (dstSel),
		.aluReq    (aluReq),
		.opcode    (opcode),
		.funct     (funct),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memRdData (memRdData)
	);

endmodule

`default_nettype wire

/* design/mips16_pkg.sv */
`default_nettype none

`include "mips16_defs.svh"

package mips16_pkg;

	// ------------------------------
	// instruction word views
	// ------------------------------
	typedef struct packed {
		logic [2:0] rd;
		logic [3:0] funct;
		logic [2:0] rt;
		logic [2:0] rs;
		logic [2:0] op;
	} rFmt_t;

	typedef struct packed {
		logic [6:0] imm7;               // jal target is imm7,rt,rs
		logic [2:0] rt;
		logic [2:0] rs;
		logic [2:0] op;
	} iFmt_t;

	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
	} instrWord_t;

	typedef enum logic [2:0] {
		ADD,
		AND,
		NOT,                            // of a only
		SUB,
		SLT,                            // unsigned compare
		PASS                            // forwards b
	} aluOp_t;

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		EXEC_R,
		EXEC_I,
		WB_ALU,
		ADDR,
		MEM_RD,
		WB_LOAD,
		MEM_WR,
		BRANCH,
		JUMP
	} cpuState_t;

	// R-type funct decode, unknown codes fall back to add
	function automatic aluOp_t functOp(input logic [3:0] funct);
		case (funct)
			`FN_ADD: return ADD;
			`FN_AND: return AND;
			`FN_NOT: return NOT;
			`FN_SUB: return SUB;
			default: return ADD;
		endcase
	endfunction

endpackage

`default_nettype wire

/* design/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module registerFile (
	input  logic              clock,
	input  logic              rst,
	input  logic [`REG_AW-1:0] rdAddrA,
	input  logic [`REG_AW-1:0] rdAddrB,
	input  logic [`REG_AW-1:0] wrAddr,
	input  logic              wrEn,
	input  logic [`DATA_W-1:0] wrData,
	output logic [`DATA_W-1:0] rdDataA,
	output logic [`DATA_W-1:0] rdDataB
);
	logic [`DATA_W-1:0] regs [`REG_CNT];

	assign rdDataA = regs[rdAddrA];     // rs
	assign rdDataB = regs[rdAddrB];     // rt

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end
		else if (wrEn)
			regs[wrAddr] <= wrData;
	end

endmodule

`default_nettype wire

/* include/mips16_defs.svh */
`ifndef MIPS16_DEFS_SVH
`define MIPS16_DEFS_SVH

// ------------------------------
// sizes
// ------------------------------
`define DATA_W    16
`define REG_CNT   8
`define REG_AW    3

// ------------------------------
// opcodes, instruction bits 2..0
// ------------------------------
`define OP_RTYPE  3'd0
`define OP_SLTI   3'd2
`define OP_ADDI   3'd3
`define OP_LB     3'd4
`define OP_SW     3'd5
`define OP_BEQ    3'd6
`define OP_JAL    3'd7

// R-type funct codes, bits 12..9
`define FN_ADD    4'd0
`define FN_AND    4'd1
`define FN_NOT    4'd2
`define FN_SUB    4'd4

`define LINK_REG  3'd7          // return address for jal

// datapath select encodings
`define BSEL_REG    2'd0        // B register
`define BSEL_TWO    2'd1        // constant 2, PC step
`define BSEL_BROFF  2'd2        // sign-extended imm7 << 1
`define BSEL_IMM    2'd3        // imm7, zero- or sign-extended by opcode

`define WBSEL_ALU   2'd0
`define WBSEL_MDR   2'd1
`define WBSEL_PC    2'd2

`define DST_RD      2'd0
`define DST_RT      2'd1
`define DST_LINK    2'd2

`endif

/* tests/mips16Checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module mips16Checker #(
	parameter logic [15:0] HALT_ADDR = 16'd160
) (
	input logic        clock,
	input logic        rst,
	input logic [15:0] memAddr,
	input logic        memRead,
	input logic        memWrite,
	input logic [15:0] memWrData,
	input logic [15:0] memRdData
);
	import mips16_pkg::*;

	// test numbers, also used as register tags
	localparam int T_FETCH  = 1;
	localparam int T_ALU    = 2;
	localparam int T_IMM    = 3;
	localparam int T_LOAD   = 4;
	localparam int T_BRANCH = 5;
	localparam int T_JAL    = 6;

	logic [15:0] pc;
	logic [15:0] regs [8];
	logic [15:0] expAddr;
	logic [15:0] expData;
	logic [2:0]  loadReg;
	logic        halted;
	int          tag [8];
	int          fetchTag;
	int          storeTag;
	int          phase;                 // 0 fetch, 1 load, 2 store
	int          checks [1:6];
	int          errs [1:6];

	task automatic compare(input int t, input string name, input logic [15:0] exp,
			input logic [15:0] act);
		checks[t]++;
		if (exp !== act)
		begin
			errs[t]++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic complain(input int t, input string what);
		checks[t]++;
		errs[t]++;
		$display("Bus error: %s", what);
	endtask

	// ------------------------------
	// instruction-set model
	// ------------------------------
	task automatic execute(input instrWord_t w);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] s;
		logic [15:0] z;
		a = regs[w.iFmt.rs];
		b = regs[w.iFmt.rt];
		s = {{9{w.iFmt.imm7[6]}}, w.iFmt.imm7};
		z = {9'd0, w.iFmt.imm7};
		fetchTag = T_FETCH;
		case (w.rFmt.op)
			`OP_RTYPE:
			begin
				case (w.rFmt.funct)
					`FN_AND: regs[w.rFmt.rd] = a & b;
					`FN_NOT: regs[w.rFmt.rd] = ~a;
					`FN_SUB: regs[w.rFmt.rd] = a - b;
					default: regs[w.rFmt.rd] = a + b;      // add and unknown codes
				endcase
				tag[w.rFmt.rd] = T_ALU;
			end
			`OP_SLTI:
			begin
				regs[w.iFmt.rt] = (a < z) ? 16'd1 : 16'd0;   // unsigned
				tag[w.iFmt.rt] = T_IMM;
			end
			`OP_ADDI:
			begin
				regs[w.iFmt.rt] = a + s;
				tag[w.iFmt.rt] = T_IMM;
			end
			`OP_LB:
			begin
				expAddr = a + s;
				loadReg = w.iFmt.rt;
				phase = 1;
			end
			`OP_SW:
			begin
				expAddr = a + s;
				expData = b;
				storeTag = tag[w.iFmt.rt];
				phase = 2;
			end
			`OP_BEQ:
			begin
				if (a == b)
					pc = pc + {s[14:0], 1'b0};   // pc already points past beq
				fetchTag = T_BRANCH;
			end
			`OP_JAL:
			begin
				regs[`LINK_REG] = pc;
				tag[`LINK_REG] = T_JAL;
				pc = {pc[15:14], w[15:3], 1'b0};
				fetchTag = T_JAL;
			end
			default: ;                          // opcode 1 does nothing
		endcase
	endtask

	always @(posedge clock)
	begin
		if (rst)
		begin
			pc = '0;
			phase = 0;
			fetchTag = T_FETCH;
			halted = 1'b0;
			for (int i = 0; i < 8; i++)
			begin
				regs[i] = '0;
				tag[i] = T_FETCH;           // reset value
			end
		end
		else if (phase == 0)
		begin
			if (memWrite)
				complain(fetchTag, "store seen where an instruction fetch was due");
			else if (memRead)
			begin
				compare(fetchTag, "memAddr", pc, memAddr);
				if (pc == HALT_ADDR)
					halted = 1'b1;
				pc = pc + 16'd2;
				execute(memRdData);
			end
		end
		else if (phase == 1)
		begin
			if (memWrite)
				complain(T_LOAD, "store seen where a load read was due");
			else if (memRead)
			begin
				compare(T_LOAD, "memAddr", expAddr, memAddr);
				regs[loadReg] = {{8{memRdData[7]}}, memRdData[7:0]};
				tag[loadReg] = T_LOAD;
				phase = 0;
			end
		end
		else
		begin
			if (memRead)
				complain(storeTag, "read seen where a store was due");
			else if (memWrite)
			begin
				compare(storeTag, "memAddr", expAddr, memAddr);
				compare(storeTag, "memWrData", expData, memWrData);
				phase = 0;
			end
		end
	end

	initial
	begin
		for (int t = 1; t <= 6; t++)
		begin
			checks[t] = 0;
			errs[t] = 0;
		end
	end

endmodule

`default_nettype wire

/* tests/mips16Tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module mips16Tb;
	localparam int PROG_WORDS   = 80;          // halt loop sits at this word
	localparam int RESET_CYCLES = 3;
	localparam int LIMIT        = (PROG_WORDS + 1) * 5 + RESET_CYCLES + 20;

	logic        clock;
	logic        rst;
	logic [15:0] memAddr;
	logic        memRead;
	logic        memWrite;
	logic [15:0] memWrData;
	logic [15:0] memRdData;
	logic [15:0] mem [256];
	integer      seed;
	int          totalChecks;
	int          totalErrs;

	mips16Core dut (
		.clock     (clock),
		.rst       (rst),
		.memAddr   (memAddr),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.memWrData (memWrData),
		.memRdData (memRdData)
	);

	mips16Checker #(.HALT_ADDR(16'(2 * PROG_WORDS))) chk (
		.clock     (clock),
		.rst       (rst),
		.memAddr   (memAddr),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.memWrData (memWrData),
		.memRdData (memRdData)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ------------------------------
	// word memory, 512 bytes
	// ------------------------------
	assign memRdData = memRead ? mem[memAddr[8:1]] : 16'h0000;

	always @(posedge clock)
	begin
		if (memWrite)
			mem[memAddr[8:1]] <= memWrData;
	end

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [15:0] iWord(input logic [6:0] imm, input logic [2:0] rt,
			input logic [2:0] rs, input logic [2:0] op);
		return {imm, rt, rs, op};
	endfunction

	function automatic logic [3:0] randFunct();
		logic [3:0] codes [4];
		codes = '{`FN_ADD, `FN_AND, `FN_NOT, `FN_SUB};
		if (pick(8) < 6)
			return codes[pick(4)];
		return 4'(pick(16));                // other codes act as add
	endfunction

	// ------------------------------
	// random program
	// ------------------------------
	task automatic buildProgram();
		int i;
		int dst;
		int off;
		int rs;
		int gap;
		for (int w = 0; w < 256; w++)
			mem[w] = 16'($random(seed));
		mem[0] = iWord(7'd32, 3'd6, 3'd0, `OP_ADDI);   // r6 = 32
		for (int w = 1; w < 4; w++)
			mem[w] = {3'd6, `FN_ADD, 3'd6, 3'd6, `OP_RTYPE};   // doubled up to 256
		i = 4;
		while (i < PROG_WORDS - 1)
		begin
			dst = pick(6);                  // r6 stays the data pointer
			gap = 0;
			case (pick(8))
				0, 1: mem[i] = {3'(dst), randFunct(), 3'(pick(8)), 3'(pick(8)), `OP_RTYPE};
				2:    mem[i] = iWord(7'(pick(128)), 3'(dst), 3'(pick(8)), `OP_SLTI);
				3:    mem[i] = iWord(7'(pick(128)), 3'(dst), 3'(pick(8)), `OP_ADDI);
				4:    mem[i] = iWord({6'(pick(32)), 1'b0}, 3'(dst), 3'd6, `OP_LB);
				5:
				begin
					off = 1 + pick((PROG_WORDS - i - 1 < 6) ? PROG_WORDS - i - 1 : 6);
					rs = pick(8);
					mem[i] = iWord(7'(off), (pick(2) == 0) ? 3'(rs) : 3'(pick(8)),
						3'(rs), `OP_BEQ);        // forward only
					dst = -1;
				end
				6:
				begin
					if (i + 5 < PROG_WORDS)
						gap = 1 + pick(3);          // nop words jumped over
					for (int k = 1; k <= gap; k++)
						mem[i + k] = {13'(pick(8192)), 3'd1};
					mem[i] = {13'(i + 1 + gap), `OP_JAL};  // lands on the store below
					dst = `LINK_REG;
				end
				default:
				begin
					mem[i] = {13'(pick(8192)), 3'd1};
					dst = -1;
				end
			endcase
			if (dst >= 0)
			begin
				mem[i + 1 + gap] = iWord({6'(pick(32)), 1'b0}, 3'(dst), 3'd6, `OP_SW);
				i = i + 2 + gap;
			end
			else
				i = i + 1;
		end
		if (i < PROG_WORDS)
			mem[i] = 16'h0001;
		mem[PROG_WORDS] = iWord(7'h7f, 3'd0, 3'd0, `OP_BEQ);   // spin on itself
	endtask

	function automatic string testName(input int t);
		case (t)
			1:       return "fetch sequence";
			2:       return "R-type results";
			3:       return "addi and slti";
			4:       return "lb sign extension";
			5:       return "beq target";
			default: return "jal and link";
		endcase
	endfunction

	// watchdog
	initial
	begin
		repeat (LIMIT) @(posedge clock);
		$display("program did not finish within %0d cycles", LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		seed = 21315;
		rst = 1'b1;
		totalChecks = 0;
		totalErrs = 0;
		buildProgram();
		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0;
		while (!chk.halted)
			@(posedge clock);
		@(posedge clock);
		for (int t = 1; t <= 6; t++)
		begin
			$display("test %0d %s: %0d checks, %0d mismatches", t, testName(t),
				chk.checks[t], chk.errs[t]);
			totalChecks = totalChecks + chk.checks[t];
			totalErrs = totalErrs + chk.errs[t];
		end
		$display("total: %0d checks, %0d errors", totalChecks, totalErrs);
		if (totalErrs == 0 && totalChecks > 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/mips16_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips16_defs.svh"

module mips16Props (
	input logic               clock,
	input logic               rst,
	input logic [`DATA_W-1:0] memAddr,
	input logic               memRead,
	input logic               memWrite
);
	// ------------------------------
	// memory bus protocol
	// ------------------------------
	assert property (@(posedge clock) !(memRead && memWrite))
		else $error("memRead and memWrite are high in the same cycle");

	assert property (@(posedge clock) disable iff (rst) memWrite |=> !memWrite)
		else $error("memWrite stayed high for more than one cycle");

	assert property (@(posedge clock) rst |-> (!memRead && !memWrite))
		else $error("bus is active while rst is high");

	assert property (@(posedge clock) memRead |-> !memAddr[0])
		else $error("odd memAddr on a read");

endmodule

bind mips16Core mips16Props props (
	.clock    (clock),
	.rst      (rst),
	.memAddr  (memAddr),
	.memRead  (memRead),
	.memWrite (memWrite)
);

`default_nettype wire
